/* sd_data_input.txt */
# name dir(1=read) bytes seed corrupt nostart cmd_err stall_mask outcome
# stall_mask bit n lets the host act in cycles 16n to 16n+15 of every 512.
rd512      1 512 1a2b3c4d 0 0 0 ffffffff done
wr512      0 512 5e6f7081 0 0 0 ffffffff done
rd_crc     1 64  0badf00d 1 0 0 ffffffff crcerr
rd_nostart 1 64  12345678 0 1 0 ffffffff timeout
rd_hold    1 512 cafe0001 0 0 0 0000ffff done
wr_burst   0 512 cafe0002 0 0 0 000f000f done
cmd_crc    1 64  00c0ffee 0 0 1 ffffffff idle
rd4        1 4   00000004 0 0 0 ffffffff done
wr4        0 4   00000044 0 0 0 ffffffff done
rd64       1 64  00000064 0 0 0 ffffffff done
wr64       0 64  00000640 0 0 0 ffffffff done

/* build.f */
sd_data_pkg.sv
buf_if.sv
crc16_lanes.sv
block_buffer.sv
data_path_ctrl.sv
sd_data_top.sv
sd_data_checker.sv
tb_sd_data.sv

/* Makefile */
TOP = tb_sd_data

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator output"

test:
	verilator --binary --timing --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | awk '{ print } /^TB PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* tb_sd_data.sv */
`timescale 1ns/100ps

module tb_sd_data;
    import sd_data_pkg::*;

    logic                  clk;
    logic                  rst_n;
    logic                  cmd_done_i;
    logic                  resp_ready_i;
    logic                  crc_err_cmd_i;
    logic                  timeout_err_cmd_i;
    logic                  data_direction_i;
    logic [BLK_SIZE_W-1:0] block_size_i;
    logic [BUS_W-1:0]      dat_i;
    logic                  host_wr_i;
    logic [WORD_W-1:0]     host_wdata_i;
    logic                  host_rd_i;
    logic [BUS_W-1:0]      dat_o;
    logic                  dat_oe_o;
    logic                  sd_clk_en_o;
    logic                  tx_full_o;
    logic [WORD_W-1:0]     host_rdata_o;
    logic                  rx_empty_o;
    logic                  data_busy_o;
    logic                  data_done_o;
    logic                  timeout_err_data_o;
    logic                  crc_err_data_o;

    string lines[$];
    int    cycles;
    int    limit;

    sd_data_top i_dut (.*);
    sd_data_checker i_chk (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run still going after %0d cycles", limit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic load_tests();
        int    fd;
        int    dir;
        int    bs;
        string line;
        string nm;
        fd = $fopen("sd_data_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open sd_data_input.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0 && line[0] != "#") begin
                    if ($sscanf(line, "%s %d %d", nm, dir, bs) == 3) begin
                        lines.push_back(line);
                        limit += (2 * bs + 40 + TIMEOUT_CYCLES) * 4;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(string line);
        string             nm;
        string             outcome;
        int                dir;
        int                bs;
        int                corrupt;
        int                nostart;
        int                cmderr;
        int                c;
        int                k;
        int                w;
        int                r;
        bit                en;
        bit                fin;
        logic [31:0]       seed;
        logic [31:0]       stall;
        logic [BUS_W-1:0]  stream[$];
        logic [WORD_W-1:0] words[$];
        void'($sscanf(line, "%s %d %d %h %d %d %d %h %s", nm, dir, bs, seed,
                      corrupt, nostart, cmderr, stall, outcome));
        i_chk.begin_test(nm, dir != 0, bs, seed, outcome, stall != 32'hffff_ffff);
        words = i_chk.exp_word;
        stream = {};
        if (dir != 0 && nostart == 0) stream = i_chk.bus_nib;
        if (corrupt != 0) begin
            r = int'($urandom % 64);  // Any of the 64 CRC bits.
            stream[1 + 2 * bs + r / 4] ^= 4'(1 << (r % 4));
        end
        data_direction_i = (dir != 0);
        block_size_i = BLK_SIZE_W'(bs);
        crc_err_cmd_i = (cmderr != 0);
        cmd_done_i = 1'b1;
        resp_ready_i = 1'b1;
        if (cmderr != 0) begin
            repeat (20) @(posedge clk);
            #1;
        end else begin
            c = 0;
            k = -1;
            w = 0;
            do begin
                @(negedge clk);
                en = sd_clk_en_o;
                fin = (data_done_o || crc_err_data_o || timeout_err_data_o) && rx_empty_o;
                @(posedge clk);
                #1;
                if (en || k < 0) k++;  // Card moves on only when clocked.
                dat_i = (k < stream.size()) ? stream[k] : 4'hf;
                host_rd_i = (dir != 0) && stall[(c / 16) % 32] && !rx_empty_o;
                host_wr_i = (dir == 0) && stall[(c / 16) % 32] && !tx_full_o &&
                            w < words.size();
                if (host_wr_i) begin
                    host_wdata_i = words[w];
                    w++;
                end
                c++;
            end while (!fin);
        end
        i_chk.end_test();
        cmd_done_i = 1'b0;
        resp_ready_i = 1'b0;
        crc_err_cmd_i = 1'b0;
        host_rd_i = 1'b0;
        host_wr_i = 1'b0;
        repeat (2) @(posedge clk);
        #1;
    endtask

    initial begin
        void'($urandom(95305));
        rst_n = 1'b0;
        cmd_done_i = 1'b0;
        resp_ready_i = 1'b0;
        crc_err_cmd_i = 1'b0;
        timeout_err_cmd_i = 1'b0;
        data_direction_i = 1'b0;
        block_size_i = '0;
        dat_i = 4'hf;  // Idle bus is pulled high.
        host_wr_i = 1'b0;
        host_wdata_i = '0;
        host_rd_i = 1'b0;
        load_tests();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        foreach (lines[t]) run_test(lines[t]);
        i_chk.report();
        if (i_chk.errors == 0 && lines.size() > 0 && i_chk.tests == lines.size()) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* sd_data_checker.sv */
`timescale 1ns/100ps

module sd_data_checker (
    input logic                              clk,
    input logic [sd_data_pkg::BUS_W-1:0]     dat_o,
    input logic                              dat_oe_o,
    input logic                              sd_clk_en_o,
    input logic                              host_wr_i,
    input logic                              tx_full_o,
    input logic                              host_rd_i,
    input logic                              rx_empty_o,
    input logic [sd_data_pkg::WORD_W-1:0]    host_rdata_o,
    input logic                              data_busy_o,
    input logic                              data_done_o,
    input logic                              timeout_err_data_o,
    input logic                              crc_err_data_o
);
    import sd_data_pkg::*;

    string             name;
    logic [BUS_W-1:0]  bus_nib[$];   // Start, data, CRC and end nibbles.
    logic [WORD_W-1:0] exp_word[$];
    logic [2:0]        exp_flags;    // Done, CRC error, timeout.
    logic              tx_full_exp;
    bit                active;
    bit                is_write;
    bit                exp_stall;
    bit                busy_seen;
    int                oe_idx;
    int                rd_idx;
    int                exp_reads;
    int                tx_pushes;
    int                stall_cnt;
    int                errors;
    int                test_errors;
    int                tests;
    int                failing;

    function automatic logic [WORD_W-1:0] word_at(logic [31:0] seed, int k);
        return (seed ^ (32'(k) * 32'h9e37_79b9)) + 32'(k);
    endfunction

    // One bit of a line into its CRC16, x^16 + x^12 + x^5 + 1.
    function automatic logic [CRC_W-1:0] crc_step(logic [CRC_W-1:0] c, logic b);
        return {c[CRC_W-2:0], 1'b0} ^ ((c[CRC_W-1] ^ b) ? CRC_POLY : '0);
    endfunction

    // Words the controller has taken from the transmit FIFO so far.
    function automatic int tx_words_taken();
        int words;
        if (oe_idx == 0) return 0;
        words = 1 + (oe_idx - 1) / NIBBLES_PER_WORD;
        return (words < exp_word.size()) ? words : exp_word.size();
    endfunction

    task automatic begin_test(string tname, bit dir, int bs, logic [31:0] seed,
                              string outcome, bit stall);
        logic [CRC_W-1:0] crc [BUS_W];
        logic [BUS_W-1:0] nib;
        crc = '{default: '0};
        name = tname;
        is_write = !dir;
        exp_stall = stall;
        exp_word = {};
        bus_nib = {};
        bus_nib.push_back(4'h0);
        for (int k = 0; k < bs / 4; k++) begin
            exp_word.push_back(word_at(seed, k));
            for (int j = NIBBLES_PER_WORD - 1; j >= 0; j--) begin
                nib = exp_word[k][4*j +: 4];
                bus_nib.push_back(nib);
                for (int i = 0; i < BUS_W; i++) crc[i] = crc_step(crc[i], nib[i]);
            end
        end
        for (int b = CRC_W - 1; b >= 0; b--) begin
            for (int i = 0; i < BUS_W; i++) nib[i] = crc[i][b];
            bus_nib.push_back(nib);
        end
        bus_nib.push_back(4'hf);
        exp_flags = {outcome == "done", outcome == "crcerr", outcome == "timeout"};
        exp_reads = (dir && outcome != "timeout" && outcome != "idle") ? bs / 4 : 0;
        oe_idx = 0;
        rd_idx = 0;
        tx_pushes = 0;
        stall_cnt = 0;
        busy_seen = 0;
        test_errors = errors;
        active = 1;
    endtask

    always @(negedge clk) begin
        if (active) begin
            tx_full_exp = (tx_pushes - tx_words_taken() == FIFO_DEPTH);
            if (tx_full_o !== tx_full_exp) begin
                $display("mismatch %0s tx_full_o expected %b actual %b",
                         name, tx_full_exp, tx_full_o);
                errors++;
            end
            if (host_wr_i && !tx_full_o) tx_pushes++;
            if (data_busy_o) busy_seen = 1;
            // A write always waits for its first word, so only later stalls count.
            if (data_busy_o && !sd_clk_en_o && (!is_write || oe_idx > 0)) stall_cnt++;
            if (sd_clk_en_o && dat_oe_o) begin
                if (!is_write || oe_idx >= bus_nib.size()) begin
                    $display("test %0s: dat_oe_o high outside the write span", name);
                    errors++;
                end else if (dat_o !== bus_nib[oe_idx]) begin
                    $display("mismatch %0s nibble %0d expected %h actual %h",
                             name, oe_idx, bus_nib[oe_idx], dat_o);
                    errors++;
                end
                oe_idx++;
            end else if (sd_clk_en_o && oe_idx > 0 && oe_idx < bus_nib.size()) begin
                $display("test %0s: dat_oe_o dropped after nibble %0d", name, oe_idx);
                errors++;
            end
            if (host_rd_i && !rx_empty_o) begin
                if (rd_idx >= exp_reads) begin
                    $display("test %0s: host popped a word that was never sent", name);
                    errors++;
                end else if (host_rdata_o !== exp_word[rd_idx]) begin
                    $display("mismatch %0s word %0d expected %h actual %h",
                             name, rd_idx, exp_word[rd_idx], host_rdata_o);
                    errors++;
                end
                rd_idx++;
            end
        end
    end

    task automatic end_test();
        logic [2:0] flags;
        flags = {data_done_o, crc_err_data_o, timeout_err_data_o};
        active = 0;
        if (flags !== exp_flags) begin
            $display("mismatch %0s flags expected %b actual %b", name, exp_flags, flags);
            errors++;
        end
        if (rd_idx != exp_reads) begin
            $display("test %0s: %0d of %0d words reached the host", name, rd_idx, exp_reads);
            errors++;
        end
        if (is_write && oe_idx != bus_nib.size()) begin
            $display("test %0s: only %0d of %0d nibbles driven", name, oe_idx, bus_nib.size());
            errors++;
        end
        if (exp_flags == 3'b000 && busy_seen) begin
            $display("test %0s: data_busy_o rose without a valid start", name);
            errors++;
        end
        if (exp_stall && stall_cnt == 0) begin
            $display("test %0s: sd_clk_en_o never went low during host stalls", name);
            errors++;
        end
        tests++;
        if (errors > test_errors) begin
            failing++;
            $display("test %0s failed with %0d errors", name, errors - test_errors);
        end else begin
            $display("test %0s ok", name);
        end
    endtask

    task automatic report();
        $display("tests %0d, failing %0d, errors %0d", tests, failing, errors);
    endtask

endmodule

/* sd_data_top.sv */
`timescale 1ns/100ps

module sd_data_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cmd_done_i,
    input  logic                                resp_ready_i,
    input  logic                                crc_err_cmd_i,
    input  logic                                timeout_err_cmd_i,
    input  logic                                data_direction_i,
    input  logic [sd_data_pkg::BLK_SIZE_W-1:0]  block_size_i,
    input  logic [sd_data_pkg::BUS_W-1:0]       dat_i,
    input  logic                                host_wr_i,
    input  logic [sd_data_pkg::WORD_W-1:0]      host_wdata_i,
    input  logic                                host_rd_i,
    output logic [sd_data_pkg::BUS_W-1:0]       dat_o,
    output logic                                dat_oe_o,
    output logic                                sd_clk_en_o,
    output logic                                tx_full_o,
    output logic [sd_data_pkg::WORD_W-1:0]      host_rdata_o,
    output logic                                rx_empty_o,
    output logic                                data_busy_o,
    output logic                                data_done_o,
    output logic                                timeout_err_data_o,
    output logic                                crc_err_data_o
);
    import sd_data_pkg::*;

    logic                        crc_clr;
    logic                        crc_shift;
    logic [BUS_W-1:0]            crc_nibble;
    logic [BUS_W-1:0][CRC_W-1:0] crc_value;

    buf_if bif ();

    data_path_ctrl i_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .cmd_done_i         (cmd_done_i),
        .resp_ready_i       (resp_ready_i),
        .crc_err_cmd_i      (crc_err_cmd_i),
        .timeout_err_cmd_i  (timeout_err_cmd_i),
        .data_direction_i   (data_direction_i),
        .block_size_i       (block_size_i),
        .dat_i              (dat_i),
        .crc_value_i        (crc_value),
        .dat_o              (dat_o),
        .dat_oe_o           (dat_oe_o),
        .sd_clk_en_o        (sd_clk_en_o),
        .crc_clr_o          (crc_clr),
        .crc_shift_o        (crc_shift),
        .crc_nibble_o       (crc_nibble),
        .data_busy_o        (data_busy_o),
        .data_done_o        (data_done_o),
        .timeout_err_data_o (timeout_err_data_o),
        .crc_err_data_o     (crc_err_data_o),
        .bif                (bif)
    );

    crc16_lanes i_crc (
        .clk          (clk),
        .rst_n        (rst_n),
        .crc_clr_i    (crc_clr),
        .crc_shift_i  (crc_shift),
        .crc_nibble_i (crc_nibble),
        .crc_value_o  (crc_value)
    );

    block_buffer i_buf (
        .clk          (clk),
        .rst_n        (rst_n),
        .host_wr_i    (host_wr_i),
        .host_wdata_i (host_wdata_i),
        .host_rd_i    (host_rd_i),
        .tx_full_o    (tx_full_o),
        .host_rdata_o (host_rdata_o),
        .rx_empty_o   (rx_empty_o),
        .bif          (bif)
    );

endmodule

/* data_path_ctrl.sv */
`timescale 1ns/100ps

module data_path_ctrl (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                cmd_done_i,
    input  logic                                                resp_ready_i,
    input  logic                                                crc_err_cmd_i,
    input  logic                                                timeout_err_cmd_i,
    input  logic                                                data_direction_i,
    input  logic [sd_data_pkg::BLK_SIZE_W-1:0]                  block_size_i,
    input  logic [sd_data_pkg::BUS_W-1:0]                       dat_i,
    input  logic [sd_data_pkg::BUS_W-1:0][sd_data_pkg::CRC_W-1:0] crc_value_i,
    output logic [sd_data_pkg::BUS_W-1:0]                       dat_o,
    output logic                                                dat_oe_o,
    output logic                                                sd_clk_en_o,
    output logic                                                crc_clr_o,
    output logic                                                crc_shift_o,
    output logic [sd_data_pkg::BUS_W-1:0]                       crc_nibble_o,
    output logic                                                data_busy_o,
    output logic                                                data_done_o,
    output logic                                                timeout_err_data_o,
    output logic                                                crc_err_data_o,
    buf_if.ctrl                                                 bif
);
    import sd_data_pkg::*;

    data_state_t state;

    logic [NIB_CNT_W-1:0]          nib_cnt;
    logic [NIB_CNT_W-1:0]          nib_last;
    logic [TIMEOUT_W-1:0]          tmo_cnt;
    logic [WORD_W-1:0]             word_sr;
    logic [BUS_W-1:0][CRC_W-1:0]   crc_rx;      // CRC sent by the card.
    logic [CRC_IDX_W-1:0]          crc_bit_sel;
    logic                          push_pend;
    logic                          crc_err_q;
    logic                          tmo_err_q;

    logic start_req;
    logic bus_adv;
    logic last_nib;
    logic word_end;
    logic word_done;
    logic need_word;
    logic need_tx;
    logic stall_tx;
    logic stall_rx;
    logic crc_match;

    assign start_req = cmd_done_i && resp_ready_i && !crc_err_cmd_i && !timeout_err_cmd_i;
    assign last_nib  = (nib_cnt == nib_last);
    assign word_end  = (nib_cnt[NIB_IDX_W-1:0] == NIB_IDX_W'(NIBBLES_PER_WORD - 1));

    // Next transmit word is fetched on the eighth nibble of the current one.
    assign need_word = (state == WRITE_DATA) && word_end && !last_nib;
    assign need_tx   = (state == WRITE_START) || need_word;
    assign stall_tx  = need_tx && bif.tx_empty;
    assign stall_rx  = push_pend && bif.rx_full;

    // Card clock stops while the FIFOs cannot keep up.
    assign sd_clk_en_o = !(stall_tx || stall_rx);
    assign bus_adv     = sd_clk_en_o;

    assign word_done    = bus_adv && (state == READ_DATA) && word_end;
    assign bif.tx_rd_en = need_tx && !bif.tx_empty;
    assign bif.rx_wr_en = push_pend && !bif.rx_full;
    assign bif.rx_data  = word_sr;

    assign crc_clr_o    = (state == IDLE);
    assign crc_shift_o  = bus_adv && ((state == READ_DATA) || (state == WRITE_DATA));
    assign crc_nibble_o = (state == READ_DATA) ? dat_i : word_sr[WORD_W-1 -: BUS_W];
    assign crc_match    = (crc_rx == crc_value_i);
    assign crc_bit_sel  = CRC_IDX_W'(CRC_W - 1) - nib_cnt[CRC_IDX_W-1:0];  // MSB first.

    assign data_busy_o        = (state != IDLE) && (state != DONE) && (state != ERROR);
    assign data_done_o        = (state == DONE);
    assign crc_err_data_o     = crc_err_q;
    assign timeout_err_data_o = tmo_err_q;

    always_comb begin
        dat_o    = '0;
        dat_oe_o = 1'b0;
        case (state)
            WRITE_START: begin
                dat_oe_o = !bif.tx_empty;     // Start nibble once a word is ready.
            end
            WRITE_DATA: begin
                dat_o    = word_sr[WORD_W-1 -: BUS_W];
                dat_oe_o = 1'b1;
            end
            WRITE_CRC: begin
                for (int i = 0; i < BUS_W; i++) begin
                    dat_o[i] = crc_value_i[i][crc_bit_sel];
                end
                dat_oe_o = 1'b1;
            end
            WRITE_END: begin
                dat_o    = '1;
                dat_oe_o = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            nib_last <= {block_size_i, 1'b0} - NIB_CNT_W'(1);
        end
        if (bus_adv) begin
            case (state)
                READ_DATA: word_sr <= {word_sr[WORD_W-BUS_W-1:0], dat_i};
                READ_CRC: begin
                    for (int i = 0; i < BUS_W; i++) begin
                        crc_rx[i] <= {crc_rx[i][CRC_W-2:0], dat_i[i]};
                    end
                end
                WRITE_START: word_sr <= bif.tx_data;
                WRITE_DATA: begin
                    if (need_word) begin
                        word_sr <= bif.tx_data;
                    end else begin
                        word_sr <= {word_sr[WORD_W-BUS_W-1:0], {BUS_W{1'b0}}};
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            nib_cnt   <= '0;
            tmo_cnt   <= '0;
            push_pend <= 1'b0;
            crc_err_q <= 1'b0;
            tmo_err_q <= 1'b0;
        end else begin
            if (word_done) begin
                push_pend <= 1'b1;              // Push lands one cycle later.
            end else if (bif.rx_wr_en) begin
                push_pend <= 1'b0;
            end

            case (state)
                IDLE: begin
                    nib_cnt   <= '0;
                    tmo_cnt   <= '0;
                    crc_err_q <= 1'b0;
                    tmo_err_q <= 1'b0;
                    if (start_req) state <= data_direction_i ? WAIT_START : WRITE_START;
                end
                WAIT_START: begin
                    if (!dat_i[0]) begin
                        state <= READ_DATA;
                    end else if (tmo_cnt == TIMEOUT_W'(TIMEOUT_CYCLES - 1)) begin
                        tmo_err_q <= 1'b1;
                        state     <= ERROR;
                    end else begin
                        tmo_cnt <= tmo_cnt + TIMEOUT_W'(1);
                    end
                end
                READ_DATA, WRITE_DATA: begin
                    if (bus_adv) begin
                        if (last_nib) begin
                            nib_cnt <= '0;
                            state   <= (state == READ_DATA) ? READ_CRC : WRITE_CRC;
                        end else begin
                            nib_cnt <= nib_cnt + NIB_CNT_W'(1);
                        end
                    end
                end
                READ_CRC: begin
                    if (bus_adv) begin
                        if (nib_cnt == NIB_CNT_W'(CRC_W)) begin  // End bit.
                            crc_err_q <= !crc_match;
                            state     <= crc_match ? DONE : ERROR;
                        end else begin
                            nib_cnt <= nib_cnt + NIB_CNT_W'(1);
                        end
                    end
                end
                WRITE_START: if (bus_adv) state <= WRITE_DATA;
                WRITE_CRC: begin
                    if (bus_adv) begin
                        if (nib_cnt == NIB_CNT_W'(CRC_W - 1)) begin
                            state <= WRITE_END;
                        end else begin
                            nib_cnt <= nib_cnt + NIB_CNT_W'(1);
                        end
                    end
                end
                WRITE_END: if (bus_adv) state <= DONE;
                DONE, ERROR: if (!cmd_done_i) state <= IDLE;  // Flags held till then.
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* block_buffer.sv */
`timescale 1ns/100ps

module block_buffer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             host_wr_i,
    input  logic [sd_data_pkg::WORD_W-1:0]   host_wdata_i,
    input  logic                             host_rd_i,
    output logic                             tx_full_o,
    output logic [sd_data_pkg::WORD_W-1:0]   host_rdata_o,
    output logic                             rx_empty_o,
    buf_if.buffer                            bif
);
    import sd_data_pkg::*;

    logic [WORD_W-1:0]  tx_mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] tx_wr_ptr;
    logic [FIFO_AW-1:0] tx_rd_ptr;
    logic [FIFO_AW:0]   tx_count;
    logic               tx_push;
    logic               tx_pop;

    logic [WORD_W-1:0]  rx_mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] rx_wr_ptr;
    logic [FIFO_AW-1:0] rx_rd_ptr;
    logic [FIFO_AW:0]   rx_count;
    logic               rx_push;
    logic               rx_pop;

    // Host fills the transmit side, controller drains it.
    assign tx_full_o    = (tx_count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign bif.tx_empty = (tx_count == '0);
    assign bif.tx_data  = tx_mem[tx_rd_ptr];     // Fall-through head.
    assign tx_push      = host_wr_i && !tx_full_o;
    assign tx_pop       = bif.tx_rd_en && !bif.tx_empty;

    // Controller fills the receive side, host drains it.
    assign bif.rx_full  = (rx_count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign rx_empty_o   = (rx_count == '0);
    assign host_rdata_o = rx_mem[rx_rd_ptr];
    assign rx_push      = bif.rx_wr_en && !bif.rx_full;
    assign rx_pop       = host_rd_i && !rx_empty_o;

    always_ff @(posedge clk) begin
        if (tx_push) tx_mem[tx_wr_ptr] <= host_wdata_i;
        if (rx_push) rx_mem[rx_wr_ptr] <= bif.rx_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_wr_ptr <= '0;
            tx_rd_ptr <= '0;
            tx_count  <= '0;
            rx_wr_ptr <= '0;
            rx_rd_ptr <= '0;
            rx_count  <= '0;
        end else begin
            if (tx_push) tx_wr_ptr <= tx_wr_ptr + 1'b1;  // Wraps at depth.
            if (tx_pop)  tx_rd_ptr <= tx_rd_ptr + 1'b1;
            case ({tx_push, tx_pop})
                2'b10:   tx_count <= tx_count + 1'b1;
                2'b01:   tx_count <= tx_count - 1'b1;
                default: tx_count <= tx_count;
            endcase

            if (rx_push) rx_wr_ptr <= rx_wr_ptr + 1'b1;
            if (rx_pop)  rx_rd_ptr <= rx_rd_ptr + 1'b1;
            case ({rx_push, rx_pop})
                2'b10:   rx_count <= rx_count + 1'b1;
                2'b01:   rx_count <= rx_count - 1'b1;
                default: rx_count <= rx_count;
            endcase
        end
    end

endmodule

/* crc16_lanes.sv */
`timescale 1ns/100ps

module crc16_lanes (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                crc_clr_i,
    input  logic                                                crc_shift_i,
    input  logic [sd_data_pkg::BUS_W-1:0]                       crc_nibble_i,
    output logic [sd_data_pkg::BUS_W-1:0][sd_data_pkg::CRC_W-1:0] crc_value_o
);
    import sd_data_pkg::*;

    logic [BUS_W-1:0] feedback;

    // Each line carries its own bit of the nibble.
    always_comb begin
        for (int i = 0; i < BUS_W; i++) begin
            feedback[i] = crc_value_o[i][CRC_W-1] ^ crc_nibble_i[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_value_o <= '0;
        end else if (crc_clr_i) begin
            crc_value_o <= '0;
        end else if (crc_shift_i) begin
            for (int i = 0; i < BUS_W; i++) begin
                crc_value_o[i] <= {crc_value_o[i][CRC_W-2:0], 1'b0} ^
                                  (feedback[i] ? CRC_POLY : '0);
            end
        end
    end

endmodule

/* buf_if.sv */
`timescale 1ns/100ps

interface buf_if;
    import sd_data_pkg::*;

    // Transmit FIFO, head word shown combinationally.
    logic [WORD_W-1:0] tx_data;
    logic              tx_empty;
    logic              tx_rd_en;   // Pops one word per cycle.

    // Receive FIFO.
    logic [WORD_W-1:0] rx_data;
    logic              rx_wr_en;   // Pushes one word per cycle.
    logic              rx_full;

    modport ctrl (
        input  tx_data,
        input  tx_empty,
        output tx_rd_en,
        output rx_data,
        output rx_wr_en,
        input  rx_full
    );

    modport buffer (
        output tx_data,
        output tx_empty,
        input  tx_rd_en,
        input  rx_data,
        input  rx_wr_en,
        output rx_full
    );

endinterface

/* sd_data_pkg.sv */
package sd_data_pkg;

    // SD data bus and FIFO word.
    localparam int BUS_W            = 4;
    localparam int WORD_W           = 32;
    localparam int NIBBLES_PER_WORD = 8;

    // Per-line CRC16, CCITT polynomial, zero start value.
    localparam int               CRC_W    = 16;
    localparam logic [CRC_W-1:0] CRC_POLY = 16'h1021;

    // Block size in bytes.
    localparam int BLK_SIZE_W = 12;
    localparam int NIB_CNT_W  = BLK_SIZE_W + 1;  // Two nibbles per byte.

    // Counter index widths.
    localparam int NIB_IDX_W = $clog2(NIBBLES_PER_WORD);
    localparam int CRC_IDX_W = $clog2(CRC_W);

    // Read start bit window.
    localparam int TIMEOUT_CYCLES = 4096;
    localparam int TIMEOUT_W      = $clog2(TIMEOUT_CYCLES);

    // Block buffer FIFOs.
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;

    typedef enum logic [3:0] {
        IDLE,
        WAIT_START,
        READ_DATA,
        READ_CRC,
        WRITE_START,
        WRITE_DATA,
        WRITE_CRC,
        WRITE_END,
        DONE,
        ERROR
    } data_state_t;

endpackage
